//--- verilog/cpuPkg.sv
package cpuPkg;

  //////////////////////////////////////////////////
  // Basic types
  //////////////////////////////////////////////////
  typedef logic [31:0] word;     // Data, address and instruction
  typedef logic [4:0]  regAddr;  // Register number
  typedef logic [5:0]  opcode;   // Primary opcode field
  typedef logic [5:0]  funct;    // R-type function field

  // ALU operations
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluNor,
    aluSlt,
    aluSltu,
    aluSll,
    aluSrl,
    aluSra,
    aluLui
  } aluOp;

  //////////////////////////////////////////////////
  // Instruction encodings
  //////////////////////////////////////////////////
  localparam opcode opRType = 6'h00;
  localparam opcode opJ     = 6'h02;
  localparam opcode opJal   = 6'h03;
  localparam opcode opBeq   = 6'h04;
  localparam opcode opBne   = 6'h05;
  localparam opcode opAddiu = 6'h09;
  localparam opcode opSlti  = 6'h0A;
  localparam opcode opSltiu = 6'h0B;
  localparam opcode opAndi  = 6'h0C;
  localparam opcode opOri   = 6'h0D;
  localparam opcode opXori  = 6'h0E;
  localparam opcode opLui   = 6'h0F;
  localparam opcode opLw    = 6'h23;
  localparam opcode opSw    = 6'h2B;

  // Function codes under opRType
  localparam funct fnSll  = 6'h00;
  localparam funct fnSrl  = 6'h02;
  localparam funct fnSra  = 6'h03;
  localparam funct fnSllv = 6'h04;  // Shift amount from rs
  localparam funct fnSrlv = 6'h06;
  localparam funct fnSrav = 6'h07;
  localparam funct fnJr   = 6'h08;
  localparam funct fnAddu = 6'h21;
  localparam funct fnSubu = 6'h23;
  localparam funct fnAnd  = 6'h24;
  localparam funct fnOr   = 6'h25;
  localparam funct fnXor  = 6'h26;
  localparam funct fnNor  = 6'h27;
  localparam funct fnSlt  = 6'h2A;
  localparam funct fnSltu = 6'h2B;

  //////////////////////////////////////////////////
  // Memory map
  //////////////////////////////////////////////////
  localparam int imemDepthLog2 = 8;  // 256 instruction words
  localparam int dmemDepthLog2 = 8;  // 256 data words

  localparam word ioBase    = 32'hFFFF_FC00;
  localparam word ioInAddr  = ioBase;
  localparam word ioOutAddr = ioBase + 32'd4;

  // Stack pointer starts at the top data word
  localparam word    spStart = 32'h0000_03FC;
  localparam regAddr spReg   = 5'd29;
  localparam regAddr linkReg = 5'd31;

endpackage

//--- verilog/fetchUnit.sv
module fetchUnit (
  input  logic        clock,
  input  logic        reset,
  input  logic        progWrite,
  input  cpuPkg::word progAddr,      // Byte address of the loaded word
  input  cpuPkg::word progData,
  input  logic        branchEq,
  input  logic        branchNe,
  input  logic        jump,
  input  logic        jumpReg,
  input  logic        zero,
  input  cpuPkg::word branchTarget,
  input  cpuPkg::word jumpRegAddr,
  output cpuPkg::word instruction,
  output cpuPkg::word pcPlus4
);
  import cpuPkg::*;

  word  pc;
  word  nextPc;
  logic branchTaken;
  word  imem [0:(1 << imemDepthLog2) - 1];

  // Word-addressed instruction RAM, asynchronous read
  assign instruction = imem[pc[imemDepthLog2 + 1:2]];
  assign pcPlus4     = pc + 32'd4;

  assign branchTaken = (branchEq && zero) || (branchNe && !zero);

  //////////////////////////////////////////////////
  // Next PC, highest priority first
  //////////////////////////////////////////////////
  always_comb begin
    if (jumpReg) begin
      nextPc = jumpRegAddr;  // jr
    end else if (jump) begin
      // j and jal keep the top four bits of the next PC
      nextPc = {pcPlus4[31:28], instruction[25:0], 2'b00};
    end else if (branchTaken) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

  // Program load only while the core is held in reset
  always_ff @(posedge clock) begin
    if (reset && progWrite) begin
      imem[progAddr[imemDepthLog2 + 1:2]] <= progData;
    end
  end

  // A bad jr target from the register file would show up here
  pcAligned: assert property (@(posedge clock) disable iff (reset) nextPc[1:0] == 2'b00)
    else $error("fetchUnit: next PC %h is not word aligned", nextPc);

endmodule

//--- verilog/controlUnit.sv
module controlUnit (
  input  cpuPkg::word  instruction,
  output logic         regWrite,
  output logic         regDst,
  output logic         jal,
  output logic         memToReg,
  output logic         memRead,
  output logic         memWrite,
  output logic         aluSrc,
  output logic         shiftByImm,
  output logic         branchEq,
  output logic         branchNe,
  output logic         jump,
  output logic         jumpReg,
  output cpuPkg::aluOp aluOperation,
  output logic         zeroExtend
);
  import cpuPkg::*;

  opcode opField;
  funct  fnField;

  assign opField = instruction[31:26];
  assign fnField = instruction[5:0];

  always_comb begin
    // Defaults give a no-op, so unknown encodings write nothing
    regWrite     = 1'b0;
    regDst       = 1'b0;
    jal          = 1'b0;
    memToReg     = 1'b0;
    memRead      = 1'b0;
    memWrite     = 1'b0;
    aluSrc       = 1'b0;
    shiftByImm   = 1'b0;
    branchEq     = 1'b0;
    branchNe     = 1'b0;
    jump         = 1'b0;
    jumpReg      = 1'b0;
    zeroExtend   = 1'b0;
    aluOperation = aluAdd;

    case (opField)
      opRType: begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        case (fnField)
          fnAddu: aluOperation = aluAdd;
          fnSubu: aluOperation = aluSub;
          fnAnd:  aluOperation = aluAnd;
          fnOr:   aluOperation = aluOr;
          fnXor:  aluOperation = aluXor;
          fnNor:  aluOperation = aluNor;
          fnSlt:  aluOperation = aluSlt;
          fnSltu: aluOperation = aluSltu;
          fnSll, fnSrl, fnSra: begin
            shiftByImm   = 1'b1;  // Amount from shamt
            aluOperation = (fnField == fnSll) ? aluSll :
                           (fnField == fnSrl) ? aluSrl : aluSra;
          end
          fnSllv: aluOperation = aluSll;
          fnSrlv: aluOperation = aluSrl;
          fnSrav: aluOperation = aluSra;
          fnJr: begin
            regWrite = 1'b0;
            jumpReg  = 1'b1;
          end
          default: regWrite = 1'b0;
        endcase
      end

      //////////////////////////////////////////////////
      // Jumps and branches
      //////////////////////////////////////////////////
      opJ:   jump = 1'b1;
      opJal: begin
        jump     = 1'b1;
        jal      = 1'b1;  // Link into r31
        regWrite = 1'b1;
      end
      opBeq: branchEq = 1'b1;
      opBne: branchNe = 1'b1;

      // Immediate forms
      opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
        regWrite   = 1'b1;
        aluSrc     = 1'b1;
        zeroExtend = (opField == opAndi) || (opField == opOri) ||
                     (opField == opXori) || (opField == opSltiu);
        case (opField)
          opSlti:  aluOperation = aluSlt;
          opSltiu: aluOperation = aluSltu;
          opAndi:  aluOperation = aluAnd;
          opOri:   aluOperation = aluOr;
          opXori:  aluOperation = aluXor;
          opLui:   aluOperation = aluLui;
          default: aluOperation = aluAdd;
        endcase
      end

      opLw: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        memRead  = 1'b1;
        memToReg = 1'b1;
      end
      opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- verilog/decodeUnit.sv
module decodeUnit (
  input  logic        clock,
  input  logic        reset,
  input  cpuPkg::word instruction,
  input  cpuPkg::word memData,     // Load data from RAM or I/O
  input  cpuPkg::word aluResult,
  input  cpuPkg::word pcPlus4,     // Return address for jal
  input  logic        jal,
  input  logic        regWrite,
  input  logic        memToReg,
  input  logic        regDst,
  input  logic        zeroExtend,
  output cpuPkg::word readData1,
  output cpuPkg::word readData2,
  output cpuPkg::word immExtended
);
  import cpuPkg::*;

  regAddr      rs;
  regAddr      rt;
  regAddr      rd;
  logic [15:0] immediate;

  regAddr writeAddr;
  word    writeData;
  word    regFile [0:31];

  assign rs        = instruction[25:21];
  assign rt        = instruction[20:16];
  assign rd        = instruction[15:11];
  assign immediate = instruction[15:0];

  // Logical immediates and sltiu use zero extension
  assign immExtended = zeroExtend ? {16'b0, immediate} : {{16{immediate[15]}}, immediate};

  // Combinational operand read
  assign readData1 = regFile[rs];
  assign readData2 = regFile[rt];

  //////////////////////////////////////////////////
  // Writeback
  //////////////////////////////////////////////////
  always_comb begin
    if (jal) begin
      writeAddr = linkReg;
      writeData = pcPlus4;
    end else begin
      writeAddr = regDst ? rd : rt;
      writeData = memToReg ? memData : aluResult;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regFile[i] <= '0;
      end
      regFile[spReg] <= spStart;  // Stack pointer
    end else if (regWrite && writeAddr != '0) begin
      regFile[writeAddr] <= writeData;  // r0 stays zero
    end
  end

endmodule

//--- verilog/executeUnit.sv
module executeUnit (
  input  cpuPkg::word  readData1,
  input  cpuPkg::word  readData2,
  input  cpuPkg::word  immExtended,
  input  cpuPkg::word  pcPlus4,
  input  cpuPkg::word  instruction,
  input  logic         aluSrc,
  input  logic         shiftByImm,
  input  cpuPkg::aluOp aluOperation,
  output cpuPkg::word  aluResult,
  output logic         zero,
  output cpuPkg::word  branchTarget
);
  import cpuPkg::*;

  word        operandB;
  logic [4:0] shiftAmount;

  assign operandB = aluSrc ? immExtended : readData2;

  // shamt field for sll/srl/sra, rs for the variable forms
  assign shiftAmount = shiftByImm ? instruction[10:6] : readData1[4:0];

  //////////////////////////////////////////////////
  // ALU and shifter
  //////////////////////////////////////////////////
  always_comb begin
    case (aluOperation)
      aluAdd:  aluResult = readData1 + operandB;
      aluSub:  aluResult = readData1 - operandB;
      aluAnd:  aluResult = readData1 & operandB;
      aluOr:   aluResult = readData1 | operandB;
      aluXor:  aluResult = readData1 ^ operandB;
      aluNor:  aluResult = ~(readData1 | operandB);
      aluSlt: begin
        aluResult = {31'b0, $signed(readData1) < $signed(operandB)};
      end
      aluSltu: begin
        aluResult = {31'b0, readData1 < operandB};
      end
      // Shifts act on rt
      aluSll:  aluResult = readData2 << shiftAmount;
      aluSrl:  aluResult = readData2 >> shiftAmount;
      aluSra:  aluResult = word'($signed(readData2) >>> shiftAmount);
      aluLui:  aluResult = {operandB[15:0], 16'b0};
      default: aluResult = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Branch support
  //////////////////////////////////////////////////
  // Compare the raw register operands, not operandB
  assign zero = (readData1 == readData2);

  // Offset counts words from the following instruction
  assign branchTarget = pcPlus4 + {immExtended[29:0], 2'b00};

endmodule

//--- verilog/memoryUnit.sv
module memoryUnit (
  input  logic        clock,
  input  logic        reset,
  input  cpuPkg::word address,    // Byte address from the ALU
  input  cpuPkg::word writeData,
  input  logic        memRead,
  input  logic        memWrite,
  input  cpuPkg::word ioIn,
  output cpuPkg::word memData,
  output cpuPkg::word ioOut,
  output logic        ioWrite
);
  import cpuPkg::*;

  logic ioSelect;
  logic ioOutStore;
  word  ramData;
  word  dmem [0:(1 << dmemDepthLog2) - 1];

  assign ioSelect   = (address >= ioBase);  // Top of the address space
  assign ioOutStore = memWrite && (address == ioOutAddr);
  assign ramData    = dmem[address[dmemDepthLog2 + 1:2]];

  always_comb begin
    if (!memRead) begin
      memData = '0;
    end else if (!ioSelect) begin
      memData = ramData;
    end else if (address == ioInAddr) begin
      memData = ioIn;
    end else if (address == ioOutAddr) begin
      memData = ioOut;  // Output word reads back
    end else begin
      memData = '0;
    end
  end

  // Data RAM write
  always_ff @(posedge clock) begin
    if (memWrite && !ioSelect) begin
      dmem[address[dmemDepthLog2 + 1:2]] <= writeData;
    end
  end

  //////////////////////////////////////////////////
  // Output port
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      ioOut   <= '0;
      ioWrite <= 1'b0;
    end else begin
      ioWrite <= ioOutStore;  // Pulse for one cycle
      if (ioOutStore) ioOut <= writeData;
    end
  end

  // Base register plus offset must land on a word
  accessAligned: assert property (@(posedge clock) disable iff (reset)
    (memRead || memWrite) |-> address[1:0] == 2'b00)
    else $error("memoryUnit: unaligned access at %h", address);

endmodule

//--- verilog/cpuTop.sv
module cpuTop (
  input  logic        clock,
  input  logic        reset,
  input  logic        progWrite,
  input  cpuPkg::word progAddr,
  input  cpuPkg::word progData,
  input  cpuPkg::word ioIn,
  output cpuPkg::word ioOut,
  output logic        ioWrite
);
  import cpuPkg::*;

  //////////////////////////////////////////////////
  // Interconnect
  //////////////////////////////////////////////////
  word  instruction;
  word  pcPlus4;
  word  readData1;
  word  readData2;
  word  immExtended;
  word  aluResult;
  word  branchTarget;
  word  memData;
  logic zero;

  // Control strobes
  logic regWrite, regDst, jal, memToReg;
  logic memRead, memWrite, aluSrc, shiftByImm;
  logic branchEq, branchNe, jump, jumpReg, zeroExtend;
  aluOp aluOperation;

  fetchUnit fetch (
    .clock(clock), .reset(reset),
    .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
    .branchEq(branchEq), .branchNe(branchNe), .jump(jump), .jumpReg(jumpReg),
    .zero(zero), .branchTarget(branchTarget),
    .jumpRegAddr(readData1),  // jr target is rs
    .instruction(instruction), .pcPlus4(pcPlus4)
  );

  controlUnit control (
    .instruction(instruction),
    .regWrite(regWrite), .regDst(regDst), .jal(jal), .memToReg(memToReg),
    .memRead(memRead), .memWrite(memWrite), .aluSrc(aluSrc), .shiftByImm(shiftByImm),
    .branchEq(branchEq), .branchNe(branchNe), .jump(jump), .jumpReg(jumpReg),
    .aluOperation(aluOperation), .zeroExtend(zeroExtend)
  );

  decodeUnit decode (
    .clock(clock), .reset(reset),
    .instruction(instruction), .memData(memData), .aluResult(aluResult),
    .pcPlus4(pcPlus4), .jal(jal), .regWrite(regWrite), .memToReg(memToReg),
    .regDst(regDst), .zeroExtend(zeroExtend),
    .readData1(readData1), .readData2(readData2), .immExtended(immExtended)
  );

  executeUnit execute (
    .readData1(readData1), .readData2(readData2), .immExtended(immExtended),
    .pcPlus4(pcPlus4), .instruction(instruction),
    .aluSrc(aluSrc), .shiftByImm(shiftByImm), .aluOperation(aluOperation),
    .aluResult(aluResult), .zero(zero), .branchTarget(branchTarget)
  );

  // rt supplies the store data
  memoryUnit memory (
    .clock(clock), .reset(reset),
    .address(aluResult), .writeData(readData2),
    .memRead(memRead), .memWrite(memWrite), .ioIn(ioIn),
    .memData(memData), .ioOut(ioOut), .ioWrite(ioWrite)
  );

endmodule

//--- sim/clockGen.sv
module clockGen (
  output logic clock,
  output logic reset
);

  localparam int halfPeriod = 50;  // 100-unit period

  initial begin
    clock = 1'b0;
    forever #halfPeriod clock = ~clock;
  end

  // Power-on reset over the first two rising edges
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    #10 reset = 1'b0;
  end

endmodule

//--- sim/cpuTb.sv
module cpuTb;
  import cpuPkg::*;

  localparam int  driveDelay  = 10;
  localparam int  clockPeriod = 100;
  localparam int  testCount   = 5;
  localparam int  testCycles  = 300;   // Watchdog share per test
  localparam int  runBudget   = 200;   // Cycles allowed to collect outputs
  localparam int  quietCycles = 20;
  localparam word stackTop    = 32'h0000_03FC;
  localparam logic [15:0] inOffset  = 16'hFC00;  // Sign-extends to the input word
  localparam logic [15:0] outOffset = 16'hFC04;

  logic powerReset;
  logic loadReset;
  logic reset;
  logic clock;
  logic progWrite;
  word  progAddr;
  word  progData;
  word  ioIn;
  word  ioOut;
  logic ioWrite;

  word         progWords[$];
  word         expected[$];
  logic [15:0] lfsrState = 16'd41;

  assign reset = powerReset || loadReset;

  clockGen clocks (.clock(clock), .reset(powerReset));

  cpuTop DUT (
    .clock(clock), .reset(reset),
    .progWrite(progWrite), .progAddr(progAddr), .progData(progData),
    .ioIn(ioIn), .ioOut(ioOut), .ioWrite(ioWrite)
  );

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  function automatic logic lfsrBit();
    logic feedback;
    feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], feedback};
    return feedback;
  endfunction

  function automatic word randomWord(input int bits);
    word value;
    value = '0;
    for (int i = 0; i < bits; i++) begin
      value = {value[30:0], lfsrBit()};
    end
    return value;
  endfunction

  // MIPS encoders
  function automatic word rType(input regAddr rs, input regAddr rt, input regAddr rd,
                                input logic [4:0] shamt, input funct fn);
    return {opRType, rs, rt, rd, shamt, fn};
  endfunction

  function automatic word iType(input opcode op, input regAddr rs, input regAddr rt,
                                input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word jType(input opcode op, input word target);
    return {op, target[27:2]};
  endfunction

  function automatic word currentPc();
    return word'(progWords.size() * 4);
  endfunction

  // Word offset from the slot after the branch being emitted
  function automatic logic [15:0] branchOffset(input int target);
    return 16'(target - progWords.size() - 1);
  endfunction

  task automatic loadConst(input regAddr r, input word value);
    progWords.push_back(iType(opLui, 5'd0, r, value[31:16]));
    progWords.push_back(iType(opOri, r, r, value[15:0]));
  endtask

  task automatic storeOut(input regAddr r);
    progWords.push_back(iType(opSw, 5'd0, r, outOffset));
  endtask

  task automatic pushResultOp(input word instr, input word want);
    progWords.push_back(instr);  // Result always lands in r10
    storeOut(5'd10);
    expected.push_back(want);
  endtask

  task automatic halt();
    progWords.push_back(jType(opJ, currentPc()));  // Spin in place
  endtask

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic checkValue(input string what, input word actual, input word want);
    if (actual !== want) begin
      abortRun($sformatf("mismatch at time %0t: %s got %h, expected %h",
                         $time, what, actual, want));
    end
  endtask

  // Load under reset, release, then compare every ioWrite pulse in order
  task automatic runProgram(input string name, input word inputValue);
    int cycles;
    int index;
    @(posedge clock);
    #driveDelay;
    loadReset = 1'b1;
    ioIn      = inputValue;
    foreach (progWords[i]) begin
      progWrite = 1'b1;
      progAddr  = word'(i) << 2;
      progData  = progWords[i];
      @(posedge clock);
      #driveDelay;
    end
    progWrite = 1'b0;
    loadReset = 1'b0;
    index     = 0;
    cycles    = 0;
    while (index < expected.size() && cycles < runBudget) begin
      @(negedge clock);  // ioWrite and ioOut settled
      if (ioWrite) begin
        checkValue($sformatf("%s output %0d", name, index), ioOut, expected[index]);
        index++;
      end
      cycles++;
    end
    if (index < expected.size()) begin
      abortRun($sformatf("%s: only %0d of %0d outputs appeared",
                         name, index, expected.size()));
    end
    repeat (quietCycles) begin
      @(negedge clock);
      if (ioWrite) begin
        abortRun($sformatf("%s: unexpected extra output %h", name, ioOut));
      end
    end
    progWords.delete();
    expected.delete();
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic testRegisterArithmetic();
    word a;
    word b;
    a = randomWord(32);
    b = randomWord(32);
    loadConst(5'd8, a);
    loadConst(5'd9, b);
    pushResultOp(rType(5'd8, 5'd9, 5'd10, 5'd0, fnAddu), a + b);
    pushResultOp(rType(5'd8, 5'd9, 5'd10, 5'd0, fnSubu), a - b);
    pushResultOp(rType(5'd8, 5'd9, 5'd10, 5'd0, fnAnd), a & b);
    pushResultOp(rType(5'd8, 5'd9, 5'd10, 5'd0, fnOr), a | b);
    pushResultOp(rType(5'd8, 5'd9, 5'd10, 5'd0, fnXor), a ^ b);
    pushResultOp(rType(5'd8, 5'd9, 5'd10, 5'd0, fnNor), ~(a | b));
    pushResultOp(rType(5'd8, 5'd9, 5'd10, 5'd0, fnSlt), word'($signed(a) < $signed(b)));
    pushResultOp(rType(5'd9, 5'd8, 5'd10, 5'd0, fnSlt), word'($signed(b) < $signed(a)));
    pushResultOp(rType(5'd8, 5'd9, 5'd10, 5'd0, fnSltu), word'(a < b));
    pushResultOp(rType(5'd9, 5'd8, 5'd10, 5'd0, fnSltu), word'(b < a));
    halt();
    runProgram("register arithmetic", 32'd0);
  endtask

  task automatic testImmediates();
    word         a;
    word         amount;
    word         signExt;
    word         zeroExt;
    logic [15:0] imm;
    logic [4:0]  shamt;
    a       = randomWord(32) | 32'h8000_0000;  // Negative, so sra fills ones
    imm     = 16'h8000 | 16'(randomWord(15));
    amount  = randomWord(32);
    shamt   = 5'(randomWord(5));
    signExt = {{16{imm[15]}}, imm};
    zeroExt = {16'h0000, imm};
    loadConst(5'd8, a);
    loadConst(5'd11, amount);
    pushResultOp(iType(opAddiu, 5'd8, 5'd10, imm), a + signExt);
    pushResultOp(iType(opSlti, 5'd8, 5'd10, imm), word'($signed(a) < $signed(signExt)));
    pushResultOp(iType(opSlti, 5'd0, 5'd10, imm), 32'd0);
    pushResultOp(iType(opAndi, 5'd8, 5'd10, imm), a & zeroExt);
    pushResultOp(iType(opOri, 5'd8, 5'd10, imm), a | zeroExt);
    pushResultOp(iType(opXori, 5'd8, 5'd10, imm), a ^ zeroExt);
    pushResultOp(iType(opSltiu, 5'd8, 5'd10, imm), word'(a < zeroExt));
    pushResultOp(iType(opSltiu, 5'd0, 5'd10, imm), 32'd1);
    pushResultOp(iType(opLui, 5'd0, 5'd10, imm), {imm, 16'h0000});
    // Shifts by shamt, then by the low bits of r11
    pushResultOp(rType(5'd0, 5'd8, 5'd10, shamt, fnSll), a << shamt);
    pushResultOp(rType(5'd0, 5'd8, 5'd10, shamt, fnSrl), a >> shamt);
    pushResultOp(rType(5'd0, 5'd8, 5'd10, shamt, fnSra), word'($signed(a) >>> shamt));
    pushResultOp(rType(5'd11, 5'd8, 5'd10, 5'd0, fnSllv), a << amount[4:0]);
    pushResultOp(rType(5'd11, 5'd8, 5'd10, 5'd0, fnSrlv), a >> amount[4:0]);
    pushResultOp(rType(5'd11, 5'd8, 5'd10, 5'd0, fnSrav),
                 word'($signed(a) >>> amount[4:0]));
    halt();
    runProgram("immediates and shifts", 32'd0);
  endtask

  task automatic testMemoryRoundTrip();
    word values[4];
    for (int i = 0; i < 4; i++) begin
      values[i] = randomWord(32);
      loadConst(5'd8, values[i]);
      progWords.push_back(iType(opSw, 5'd29, 5'd8, 16'(-4 * i)));  // Down from the stack top
    end
    for (int i = 3; i >= 0; i--) begin
      progWords.push_back(iType(opLw, 5'd29, 5'd10, 16'(-4 * i)));
      storeOut(5'd10);
      expected.push_back(values[i]);
    end
    storeOut(5'd29);
    expected.push_back(stackTop);
    halt();
    runProgram("memory round trip", 32'd0);
  endtask

  task automatic testBranchLoop();
    word n;
    int  loopIndex;
    n = 32'd5 + randomWord(4);
    loadConst(5'd12, 32'hDEAD_BEEF);
    progWords.push_back(iType(opLw, 5'd0, 5'd8, inOffset));  // N from the input word
    loopIndex = progWords.size();
    progWords.push_back(iType(opAddiu, 5'd10, 5'd10, 16'd1));
    progWords.push_back(rType(5'd9, 5'd10, 5'd9, 5'd0, fnAddu));
    progWords.push_back(iType(opBne, 5'd10, 5'd8, branchOffset(loopIndex)));
    progWords.push_back(iType(opBeq, 5'd9, 5'd9, 16'd1));  // Always taken
    storeOut(5'd12);
    storeOut(5'd9);
    expected.push_back(n * (n + 32'd1) / 32'd2);
    halt();
    runProgram("branch loop", n);
  endtask

  task automatic testCallsAndZero();
    word tail;
    int  jalIndex;
    int  jumpIndex;
    tail = randomWord(16);
    loadConst(5'd12, 32'hDEAD_BEEF);
    progWords.push_back(iType(opAddiu, 5'd0, 5'd0, 16'h1234));
    storeOut(5'd0);
    expected.push_back(32'd0);
    jalIndex = progWords.size();
    progWords.push_back(32'd0);  // Call target patched once the subroutine is placed
    expected.push_back(word'(jalIndex * 4 + 4));
    jumpIndex = progWords.size();
    progWords.push_back(32'd0);
    storeOut(5'd12);
    progWords[jumpIndex] = jType(opJ, currentPc());
    progWords.push_back(iType(opOri, 5'd0, 5'd13, tail[15:0]));
    storeOut(5'd13);
    expected.push_back(tail);
    halt();
    // Subroutine reports its return address
    progWords[jalIndex] = jType(opJal, currentPc());
    storeOut(5'd31);
    progWords.push_back(rType(5'd31, 5'd0, 5'd0, 5'd0, fnJr));
    runProgram("calls and r0", 32'd0);
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////
  initial begin
    progWrite = 1'b0;
    progAddr  = '0;
    progData  = '0;
    ioIn      = '0;
    loadReset = 1'b1;
    testRegisterArithmetic();
    testImmediates();
    testMemoryRoundTrip();
    testBranchLoop();
    testCallsAndZero();
    $display("All tests passed");
    $finish;
  end

  initial begin
    #(testCount * testCycles * clockPeriod);
    abortRun($sformatf("timeout: the tests did not finish within %0d cycles",
                       testCount * testCycles));
  end

endmodule

//--- vlog.f
verilog/cpuPkg.sv
verilog/fetchUnit.sv
verilog/controlUnit.sv
verilog/decodeUnit.sv
verilog/executeUnit.sv
verilog/memoryUnit.sv
verilog/cpuTop.sv
sim/clockGen.sv
sim/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
FILE_LIST ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
